// ==== hdl/sq_params.svh ====
`ifndef SQ_PARAMS_SVH
`define SQ_PARAMS_SVH

// store queue geometry
`define SQ_SZ               8
`define SQ_IDX_BITS         3

// occupancy runs from 0 to SQ_SZ, so one bit wider than an index
`define SQ_NUM_ENTRIES_BITS 4

// superscalar width
`define N                   2

// wide enough for a per-cycle count of 0..N
`define NUM_SCALAR_BITS     2

// datapath
`define XLEN                32
`define NUM_BYTES           4

`endif

// ==== hdl/sq_pkg.sv ====
`default_nettype none

`include "sq_params.svh"

package sq_pkg;

    // word address that a forward compares whole
    typedef logic [`XLEN-1:0] ADDR;

    typedef union packed {
        logic [`XLEN-1:0]            word;
        logic [`NUM_BYTES-1:0][7:0]  bytes;
    } DATA;

    typedef logic [`NUM_BYTES-1:0] BYTE_MASK;

    // the wrap bit tells a full queue from an empty one
    typedef struct packed {
        logic                    wrap;
        logic [`SQ_IDX_BITS-1:0] sq_idx;
    } SQ_POINTER;

    typedef logic [`SQ_SZ-1:0] SQ_MASK;

    // one resolved store
    typedef struct packed {
        ADDR      addr;
        DATA      result;
        BYTE_MASK byte_mask;
    } STORE_QUEUE_PACKET;

endpackage

`default_nettype wire

// ==== hdl/psel_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module psel_gen #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    // above[i] is set when any request sits above bit i
    logic [WIDTH-1:0] above;

    assign above[WIDTH-1] = 1'b0;

    for (genvar i = 0; i < WIDTH - 1; i++) begin : g_above
        assign above[i] = |req[WIDTH-1:i+1];
    end

    // only the highest request survives and a zero req grants nothing
    assign gnt = req & ~above;

endmodule

`default_nettype wire

// ==== hdl/store_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module store_forward
    import sq_pkg::*;
(
    input  STORE_QUEUE_PACKET [`SQ_SZ-1:0] entries,
    input  SQ_MASK                         unresolved,
    input  SQ_POINTER                      oldest,
    input  SQ_POINTER                      load_sq_tail,
    input  ADDR                            load_req_addr,
    output DATA                            sq_load_data,
    output BYTE_MASK                       sq_data_mask
);

    localparam int PTR_BITS = `SQ_IDX_BITS + 1;

    logic [PTR_BITS-1:0] window;
    logic                window_empty;
    logic [`SQ_SZ-1:0]   addr_hit;

    // number of undrained stores older than the load
    assign window = load_sq_tail - oldest;

    // a tail that fell behind the drain head leaves nothing to search either
    assign window_empty = (window == '0) || (window > PTR_BITS'(`SQ_SZ));

    always_comb begin
        for (int j = 0; j < `SQ_SZ; j++) begin
            addr_hit[j] = !unresolved[j] && (entries[j].addr == load_req_addr);
        end
    end

    for (genvar b = 0; b < `NUM_BYTES; b++) begin : g_lane
        logic [`SQ_SZ-1:0] match;
        logic [`SQ_SZ-1:0] rotated;
        logic [`SQ_SZ-1:0] rotated_gnt;
        logic [`SQ_SZ-1:0] winner;
        logic [7:0]        lane_byte;

        always_comb begin
            for (int j = 0; j < `SQ_SZ; j++) begin
                match[j] = addr_hit[j] && entries[j].byte_mask[b];
            end
        end

        // rotate so the entry just below the load tail lands on the top bit
        always_comb begin
            logic [`SQ_IDX_BITS-1:0] src;
            for (int k = 0; k < `SQ_SZ; k++) begin
                src = load_sq_tail.sq_idx + `SQ_IDX_BITS'(k);
                rotated[k] = match[src];
                // low positions hold drained or younger entries
                if (window_empty || (k < `SQ_SZ - int'(window))) begin
                    rotated[k] = 1'b0;
                end
            end
        end

        psel_gen #(
            .WIDTH(`SQ_SZ)
        ) i_newest (
            .req(rotated),
            .gnt(rotated_gnt)
        );

        always_comb begin
            logic [`SQ_IDX_BITS-1:0] src;
            for (int j = 0; j < `SQ_SZ; j++) begin
                src = `SQ_IDX_BITS'(j) - load_sq_tail.sq_idx;
                winner[j] = rotated_gnt[src];
            end
        end

        // winner is one-hot or zero
        always_comb begin
            lane_byte = '0;
            for (int j = 0; j < `SQ_SZ; j++) begin
                if (winner[j]) begin
                    lane_byte = entries[j].result.bytes[b];
                end
            end
        end

        assign sq_load_data.bytes[b] = lane_byte;
        assign sq_data_mask[b]       = |winner;
    end

endmodule

`default_nettype wire

// ==== hdl/store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module store_queue
    import sq_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    // store unit
    input  STORE_QUEUE_PACKET           sq_packet,
    input  SQ_MASK                      resolving_sq_mask,
    // dispatch
    input  logic [`NUM_SCALAR_BITS-1:0] stores_dispatching,
    output logic [`NUM_SCALAR_BITS-1:0] sq_spots,
    output SQ_POINTER                   sq_tail,
    output SQ_MASK                      sq_mask_combinational,
    // load unit
    input  SQ_POINTER                   load_sq_tail,
    input  ADDR                         load_req_addr,
    output DATA                         sq_load_data,
    output BYTE_MASK                    sq_data_mask,
    // branch stack
    input  logic                        sq_restore_valid,
    input  SQ_POINTER                   sq_tail_restore,
    input  SQ_MASK                      sq_mask_restore,
    // data cache
    input  logic                        store_req_accepted,
    output logic                        store_req_valid,
    output DATA                         store_req_data,
    output ADDR                         store_req_addr,
    output BYTE_MASK                    store_req_byte_mask,
    // retire
    input  logic [`NUM_SCALAR_BITS-1:0] num_store_retiring
);

    localparam int PTR_BITS = `SQ_IDX_BITS + 1;
    localparam int CNT_BITS = `SQ_NUM_ENTRIES_BITS;

    STORE_QUEUE_PACKET [`SQ_SZ-1:0] entries;

    SQ_MASK sq_mask;
    SQ_MASK next_sq_mask;
    SQ_MASK dispatch_mask;

    // retire_head moves on retire, drain_head on cache accept
    SQ_POINTER retire_head;
    SQ_POINTER drain_head;
    SQ_POINTER next_retire_head;
    SQ_POINTER next_drain_head;
    SQ_POINTER next_tail;

    logic [CNT_BITS-1:0] sq_entries;
    logic [CNT_BITS-1:0] next_sq_entries;
    logic [CNT_BITS-1:0] undrained;
    logic [CNT_BITS-1:0] next_undrained;
    logic [CNT_BITS-1:0] free_slots;
    logic [PTR_BITS-1:0] unretired;

    // dispatch
    assign free_slots = CNT_BITS'(`SQ_SZ) - sq_entries;
    assign sq_spots   = (free_slots < CNT_BITS'(`N)) ? `NUM_SCALAR_BITS'(free_slots)
                                                     : `NUM_SCALAR_BITS'(`N);

    // new stores start out unresolved
    always_comb begin
        logic [`SQ_IDX_BITS-1:0] slot;
        dispatch_mask = '0;
        for (int k = 0; k < `N; k++) begin
            slot = sq_tail.sq_idx + `SQ_IDX_BITS'(k);
            if (k < int'(stores_dispatching)) begin
                dispatch_mask[slot] = 1'b1;
            end
        end
    end

    assign sq_mask_combinational = sq_mask & ~resolving_sq_mask;

    // restore wins over dispatch
    assign next_sq_mask = sq_restore_valid ? (sq_mask_restore & ~resolving_sq_mask)
                                           : (sq_mask_combinational | dispatch_mask);

    assign next_tail = sq_restore_valid ? sq_tail_restore
                                        : SQ_POINTER'(sq_tail + PTR_BITS'(stores_dispatching));

    assign next_retire_head = SQ_POINTER'(retire_head + PTR_BITS'(num_store_retiring));
    assign next_drain_head  = SQ_POINTER'(drain_head + PTR_BITS'(store_req_accepted));

    // wrap bits differ on a full queue, so the difference reads SQ_SZ there
    assign next_sq_entries = sq_restore_valid
                           ? CNT_BITS'(sq_tail_restore - next_drain_head)
                           : sq_entries + CNT_BITS'(stores_dispatching)
                                        - CNT_BITS'(store_req_accepted);

    assign next_undrained = undrained + CNT_BITS'(num_store_retiring)
                                      - CNT_BITS'(store_req_accepted);

    assign unretired = sq_tail - retire_head;

    // drain port serves the oldest retired store
    assign store_req_valid     = (undrained != '0);
    assign store_req_addr      = entries[drain_head.sq_idx].addr;
    assign store_req_data      = entries[drain_head.sq_idx].result;
    assign store_req_byte_mask = entries[drain_head.sq_idx].byte_mask;

    store_forward i_store_forward (
        .entries      (entries),
        .unresolved   (sq_mask),
        .oldest       (drain_head),
        .load_sq_tail (load_sq_tail),
        .load_req_addr(load_req_addr),
        .sq_load_data (sq_load_data),
        .sq_data_mask (sq_data_mask)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_tail     <= '0;
            retire_head <= '0;
            drain_head  <= '0;
            sq_entries  <= '0;
            undrained   <= '0;
            sq_mask     <= '0;
        end else begin
            sq_tail     <= next_tail;
            retire_head <= next_retire_head;
            drain_head  <= next_drain_head;
            sq_entries  <= next_sq_entries;
            undrained   <= next_undrained;
            sq_mask     <= next_sq_mask;
        end
    end

    // resolved store lands in its slot
    always_ff @(posedge clock) begin
        for (int i = 0; i < `SQ_SZ; i++) begin
            if (resolving_sq_mask[i]) begin
                entries[i] <= sq_packet;
            end
        end
    end

    a_dispatch_spots: assert property (@(posedge clock) disable iff (reset)
        stores_dispatching <= sq_spots)
        else $error("store_queue: dispatch %0d over %0d spots", stores_dispatching, sq_spots);

    a_accept_valid: assert property (@(posedge clock) disable iff (reset)
        store_req_accepted |-> store_req_valid)
        else $error("store_queue: accept with no store request");

    // retire can only cover stores that were dispatched
    a_retire_tail: assert property (@(posedge clock) disable iff (reset)
        PTR_BITS'(num_store_retiring) <= unretired)
        else $error("store_queue: retire %0d past tail", num_store_retiring);

    a_resolve_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(resolving_sq_mask))
        else $error("store_queue: resolve mask %h not one-hot", resolving_sq_mask);

endmodule

`default_nettype wire

// ==== hdl/store_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module store_subsystem
    import sq_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  STORE_QUEUE_PACKET           sq_packet,
    input  SQ_MASK                      resolving_sq_mask,
    input  logic [`NUM_SCALAR_BITS-1:0] stores_dispatching,
    output logic [`NUM_SCALAR_BITS-1:0] sq_spots,
    output SQ_POINTER                   sq_tail,
    output SQ_MASK                      sq_mask_combinational,
    input  SQ_POINTER                   load_sq_tail,
    input  ADDR                         load_req_addr,
    output DATA                         sq_load_data,
    output BYTE_MASK                    sq_data_mask,
    input  logic                        sq_restore_valid,
    input  SQ_POINTER                   sq_tail_restore,
    input  SQ_MASK                      sq_mask_restore,
    input  logic                        store_req_accepted,
    output logic                        store_req_valid,
    output DATA                         store_req_data,
    output ADDR                         store_req_addr,
    output BYTE_MASK                    store_req_byte_mask,
    input  logic [`NUM_SCALAR_BITS-1:0] num_store_retiring
);

    store_queue i_store_queue (
        .clock                (clock),
        .reset                (reset),
        .sq_packet            (sq_packet),
        .resolving_sq_mask    (resolving_sq_mask),
        .stores_dispatching   (stores_dispatching),
        .sq_spots             (sq_spots),
        .sq_tail              (sq_tail),
        .sq_mask_combinational(sq_mask_combinational),
        .load_sq_tail         (load_sq_tail),
        .load_req_addr        (load_req_addr),
        .sq_load_data         (sq_load_data),
        .sq_data_mask         (sq_data_mask),
        .sq_restore_valid     (sq_restore_valid),
        .sq_tail_restore      (sq_tail_restore),
        .sq_mask_restore      (sq_mask_restore),
        .store_req_accepted   (store_req_accepted),
        .store_req_valid      (store_req_valid),
        .store_req_data       (store_req_data),
        .store_req_addr       (store_req_addr),
        .store_req_byte_mask  (store_req_byte_mask),
        .num_store_retiring   (num_store_retiring)
    );

endmodule

`default_nettype wire

// ==== sim/sq_ref_model.svh ====
`ifndef SQ_REF_MODEL_SVH
`define SQ_REF_MODEL_SVH

// pointer with the wrap bit on top
typedef logic [`SQ_IDX_BITS:0] ptr_t;

// shadow slots use the queue's numbering
ADDR      m_addr  [`SQ_SZ];
DATA      m_data  [`SQ_SZ];
BYTE_MASK m_bmask [`SQ_SZ];
SQ_MASK   m_unres  = '0;
ptr_t     m_tail   = '0;
ptr_t     m_retire = '0;
ptr_t     m_drain  = '0;

function automatic int span(input ptr_t young, input ptr_t old);
    return int'(ptr_t'(young - old));
endfunction

function automatic int model_spots();
    int free_slots;
    free_slots = `SQ_SZ - span(m_tail, m_drain);
    return (free_slots < `N) ? free_slots : `N;
endfunction

// how many of the oldest stores are resolved and may retire now in order
function automatic int retire_limit();
    int n;
    n = 0;
    while (n < `N && n < span(m_tail, m_retire)
           && !m_unres[`SQ_IDX_BITS'(m_retire + ptr_t'(n))]) begin
        n++;
    end
    return n;
endfunction

// walk from just below the load tail towards the oldest undrained store
function automatic void forward_ref(input ptr_t load_tail, input ADDR addr,
                                    output DATA data, output BYTE_MASK bmask);
    int                      count;
    logic [`SQ_IDX_BITS-1:0] slot;
    data  = '0;
    bmask = '0;
    count = span(load_tail, m_drain);
    if (count > `SQ_SZ) begin
        count = 0;
    end
    for (int k = 1; k <= count; k++) begin
        slot = `SQ_IDX_BITS'(load_tail - ptr_t'(k));
        for (int b = 0; b < `NUM_BYTES; b++) begin
            if (!bmask[b] && !m_unres[slot] && m_addr[slot] == addr && m_bmask[slot][b]) begin
                bmask[b]      = 1'b1;
                data.bytes[b] = m_data[slot].bytes[b];
            end
        end
    end
endfunction

// advances the model by one rising edge on this cycle's inputs
task automatic model_step();
    for (int i = 0; i < `SQ_SZ; i++) begin
        if (resolving_sq_mask[i]) begin
            m_addr[i]  = sq_packet.addr;
            m_data[i]  = sq_packet.result;
            m_bmask[i] = sq_packet.byte_mask;
        end
    end
    if (sq_restore_valid) begin
        m_unres = sq_mask_restore & ~resolving_sq_mask;
        m_tail  = sq_tail_restore;
    end else begin
        m_unres = m_unres & ~resolving_sq_mask;
        for (int k = 0; k < int'(stores_dispatching); k++) begin
            m_unres[`SQ_IDX_BITS'(m_tail + ptr_t'(k))] = 1'b1;
        end
        m_tail = ptr_t'(m_tail + ptr_t'(stores_dispatching));
    end
    m_retire = ptr_t'(m_retire + ptr_t'(num_store_retiring));
    m_drain  = ptr_t'(m_drain + ptr_t'(store_req_accepted));
endtask

`endif

// ==== sim/store_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module store_tb
    import sq_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int SOAK_CYCLES = 600;
    // directed tests stay well below 400 cycles
    localparam int TEST_CYCLES = SOAK_CYCLES + 400;

    logic                        clock;
    logic                        reset;
    STORE_QUEUE_PACKET           sq_packet;
    SQ_MASK                      resolving_sq_mask;
    logic [`NUM_SCALAR_BITS-1:0] stores_dispatching;
    logic [`NUM_SCALAR_BITS-1:0] sq_spots;
    SQ_POINTER                   sq_tail;
    SQ_MASK                      sq_mask_combinational;
    SQ_POINTER                   load_sq_tail;
    ADDR                         load_req_addr;
    DATA                         sq_load_data;
    BYTE_MASK                    sq_data_mask;
    logic                        sq_restore_valid;
    SQ_POINTER                   sq_tail_restore;
    SQ_MASK                      sq_mask_restore;
    logic                        store_req_accepted;
    logic                        store_req_valid;
    DATA                         store_req_data;
    ADDR                         store_req_addr;
    BYTE_MASK                    store_req_byte_mask;
    logic [`NUM_SCALAR_BITS-1:0] num_store_retiring;

    integer seed              = 32'hf65f_4537;
    int     errors            = 0;
    int     checks            = 0;
    int     test_start_errors = 0;

    `include "sq_ref_model.svh"

    store_subsystem i_store_subsystem (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // outputs still show the state before this edge
    always @(posedge clock) begin : compare
        DATA      exp_data;
        BYTE_MASK exp_mask;
        if (!reset) begin
            forward_ref(load_sq_tail, load_req_addr, exp_data, exp_mask);
            compare_value("sq_spots", sq_spots, model_spots());
            compare_value("sq_tail", sq_tail, m_tail);
            compare_value("sq_mask_combinational", sq_mask_combinational,
                          m_unres & ~resolving_sq_mask);
            compare_value("sq_data_mask", sq_data_mask, exp_mask);
            compare_value("sq_load_data", sq_load_data, exp_data);
            compare_value("store_req_valid", store_req_valid, m_retire != m_drain);
            if (m_retire != m_drain) begin
                compare_value("store_req_addr", store_req_addr,
                              m_addr[m_drain[`SQ_IDX_BITS-1:0]]);
                compare_value("store_req_data", store_req_data,
                              m_data[m_drain[`SQ_IDX_BITS-1:0]]);
                compare_value("store_req_byte_mask", store_req_byte_mask,
                              m_bmask[m_drain[`SQ_IDX_BITS-1:0]]);
            end
            model_step();
        end
    end

    function automatic int rand_below(input int n);
        return (n <= 0) ? 0 : int'($unsigned($random(seed)) % n);
    endfunction

    task automatic clear_strobes();
        stores_dispatching = '0;
        resolving_sq_mask  = '0;
        num_store_retiring = '0;
        store_req_accepted = 1'b0;
        sq_restore_valid   = 1'b0;
    endtask

    // a load tail left outside the window moves to the queue tail
    task automatic tick();
        @(negedge clock);
        clear_strobes();
        if (span(load_sq_tail, m_drain) > span(m_tail, m_drain)) begin
            load_sq_tail = m_tail;
        end
    endtask

    // few distinct addresses so that stores overlap
    task automatic resolve_one();
        int slot;
        slot = rand_below(`SQ_SZ);
        while (m_unres != '0 && !m_unres[slot]) begin
            slot = (slot + 1) % `SQ_SZ;
        end
        if (m_unres[slot]) begin
            resolving_sq_mask   = SQ_MASK'(1) << slot;
            sq_packet.addr      = 32'h100 + 4 * rand_below(3);
            sq_packet.result    = $random(seed);
            sq_packet.byte_mask = BYTE_MASK'(rand_below(16));
        end
    endtask

    // keeps the first keep stores past the retire head
    task automatic restore_to(input int keep);
        SQ_MASK kept;
        kept = '0;
        for (int k = 0; k < keep; k++) begin
            kept[`SQ_IDX_BITS'(m_retire + ptr_t'(k))] = 1'b1;
        end
        sq_restore_valid = 1'b1;
        sq_tail_restore  = ptr_t'(m_retire + ptr_t'(keep));
        sq_mask_restore  = m_unres & kept;
        tick();
    endtask

    task automatic random_cycle();
        if (rand_below(40) == 0) begin
            restore_to(rand_below(span(m_tail, m_retire) + 1));
        end else begin
            stores_dispatching = `NUM_SCALAR_BITS'(rand_below(model_spots() + 1));
            if (rand_below(4) != 0) begin
                resolve_one();
            end
            num_store_retiring = `NUM_SCALAR_BITS'(rand_below(retire_limit() + 1));
            store_req_accepted = (m_retire != m_drain) && (rand_below(3) != 0);
            load_sq_tail  = ptr_t'(m_drain + ptr_t'(rand_below(span(m_tail, m_drain) + 1)));
            load_req_addr = 32'h100 + 4 * rand_below(3);
            tick();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-9s done, %0d mismatches", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        int   n;
        ptr_t restored;
        reset = 1'b1;
        clear_strobes();
        sq_packet       = '0;
        load_sq_tail    = '0;
        load_req_addr   = 32'h100;
        sq_tail_restore = '0;
        sq_mask_restore = '0;
        repeat (2) @(negedge clock);
        reset = 1'b0;

        #1;
        compare_value("sq_spots", sq_spots, `N);
        compare_value("sq_tail", sq_tail, 0);
        compare_value("store_req_valid", store_req_valid, 0);
        compare_value("sq_data_mask", sq_data_mask, 0);
        tick();
        end_test("reset");

        while (model_spots() > 0) begin
            stores_dispatching = `NUM_SCALAR_BITS'(1 + rand_below(model_spots()));
            tick();
        end
        #1;
        compare_value("sq_spots", sq_spots, 0);
        tick();
        end_test("allocate");

        // two stores stay unresolved
        repeat (6) begin
            resolve_one();
            tick();
        end
        for (int t = 0; t <= `SQ_SZ; t++) begin
            for (int a = 0; a < 3; a++) begin
                load_sq_tail  = ptr_t'(m_drain + ptr_t'(t));
                load_req_addr = 32'h100 + 4 * a;
                tick();
            end
        end
        end_test("forward");

        while (m_unres != '0) begin
            resolve_one();
            tick();
        end
        n = 0;
        while (m_drain != m_tail && n < 200) begin
            num_store_retiring = `NUM_SCALAR_BITS'(rand_below(retire_limit() + 1));
            store_req_accepted = (m_retire != m_drain) && (rand_below(2) != 0);
            tick();
            n++;
        end
        if (m_drain != m_tail) begin
            errors++;
            $display("drain stalled with %0d stores still queued", span(m_tail, m_drain));
        end
        end_test("drain");

        while (model_spots() > 0) begin
            stores_dispatching = `NUM_SCALAR_BITS'(model_spots());
            resolve_one();
            tick();
        end
        restored = ptr_t'(m_retire + 2);
        restore_to(2);
        #1;
        compare_value("sq_tail", sq_tail, restored);
        compare_value("sq_spots", sq_spots, `N);
        @(negedge clock);
        // reused slots are unresolved, stale data must not forward
        stores_dispatching = 2;
        tick();
        for (int a = 0; a < 3; a++) begin
            load_sq_tail  = m_tail;
            load_req_addr = 32'h100 + 4 * a;
            tick();
        end
        end_test("restore");

        repeat (SOAK_CYCLES) random_cycle();
        end_test("soak");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + 50));
        $display("watchdog expired after %0d cycles, tests did not complete", TEST_CYCLES + 50);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
+incdir+sim
hdl/sq_pkg.sv
hdl/psel_gen.sv
hdl/store_forward.sv
hdl/store_queue.sv
hdl/store_subsystem.sv
sim/store_tb.sv

// ==== Makefile ====
# Verilator build and run of the store queue testbench

TOP = store_tb

all: run

obj_dir/$(TOP): build.f hdl/*.sv hdl/*.svh sim/*.sv sim/*.svh
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "Simulation finished: FAIL" sim.log

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
